/* i2s_rx_pkg.sv */
package i2s_rx_pkg;

	localparam int word_width = 16; // Payload bits kept from each sample.
	localparam int header_words = 5;
	localparam int id_width = 5;

	// Oldest word sits in the top slot, matching the matcher window order.
	localparam logic [header_words-1:0][word_width-1:0] sync_header = {
		16'h0B77,
		16'hA1DD,
		16'h4240,
		16'h2F84,
		16'h2B03
	};

	typedef enum logic {
		ch_left  = 1'b0, // Lrclk low.
		ch_right = 1'b1
	} channel_t;

	typedef enum logic {
		cap_idle    = 1'b0,
		cap_payload = 1'b1
	} cap_state_t;

	typedef struct packed {
		logic [9:0]            pad;
		logic [id_width-1:0]   id;
		channel_t              channel;
		logic [word_width-1:0] word;
	} fifo_entry_t;

endpackage

/* i2s_word_if.sv */
`timescale 1ns/1ps

interface i2s_word_if import i2s_rx_pkg::*; ();

	logic [word_width-1:0] word;
	channel_t              channel;
	logic                  valid;     // One cycle per good slot.
	logic                  frame_err; // One cycle per short slot.

	modport producer (
		output word,
		output channel,
		output valid,
		output frame_err
	);

	modport consumer (
		input word,
		input channel,
		input valid,
		input frame_err
	);

endinterface

/* i2s_deserializer.sv */
`timescale 1ns/1ps

module i2s_deserializer import i2s_rx_pkg::*; #(
	parameter int sample_width = 24
) (
	input  logic       bclk,
	input  logic       rst_n,
	input  logic       lrclk,
	input  logic       sdata,
	i2s_word_if.producer words
);

	localparam int cnt_w = $clog2(sample_width + 1);

	logic                    lrclk_d1;
	logic                    lrclk_d2;
	logic                    slot_edge;
	logic [cnt_w-1:0]        bit_cnt;
	logic [sample_width-1:0] sample;

	// High on the edge that also carries the MSB of the new slot.
	assign slot_edge = lrclk_d1 != lrclk_d2;

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			lrclk_d1 <= 1'b0;
			lrclk_d2 <= 1'b0;
		end else begin
			lrclk_d1 <= lrclk;
			lrclk_d2 <= lrclk_d1;
		end
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (slot_edge) begin
			bit_cnt <= cnt_w'(1);
		end else if (bit_cnt < cnt_w'(sample_width)) begin
			bit_cnt <= bit_cnt + 1'b1; // Stops at a full sample.
		end
	end

	always_ff @(posedge bclk) begin
		if (slot_edge) begin
			sample <= {{(sample_width-1){1'b0}}, sdata};
		end else if (bit_cnt < cnt_w'(sample_width)) begin
			sample <= {sample[sample_width-2:0], sdata}; // MSB first.
		end
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			words.valid     <= 1'b0;
			words.frame_err <= 1'b0;
		end else begin
			words.valid     <= slot_edge && (bit_cnt == cnt_w'(sample_width));
			words.frame_err <= slot_edge && (bit_cnt != cnt_w'(sample_width));
		end
	end

	always_ff @(posedge bclk) begin
		if (slot_edge) begin
			words.word    <= sample[sample_width-1 -: word_width];
			words.channel <= channel_t'(lrclk_d2); // Level of the slot just ended.
		end
	end

endmodule

/* header_matcher.sv */
`timescale 1ns/1ps

module header_matcher import i2s_rx_pkg::*; (
	input  logic         bclk,
	input  logic         rst_n,
	i2s_word_if.consumer words,
	output logic         match
);

	localparam int fill_w = $clog2(header_words + 1);

	logic [header_words-1:0][word_width-1:0] window;
	logic [header_words-1:0][word_width-1:0] window_next;
	logic [fill_w-1:0]                       fill;
	logic                                    near_full;

	// Window as it will look once the current word is shifted in.
	assign window_next = {window[header_words-2:0], words.word};
	assign near_full = fill >= fill_w'(header_words - 1);

	always_ff @(posedge bclk) begin
		if (words.valid) begin
			window <= window_next;
		end
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			fill <= '0;
		end else if (words.frame_err) begin
			fill <= '0; // Broken slot restarts the search.
		end else if (words.valid && fill < fill_w'(header_words)) begin
			fill <= fill + 1'b1;
		end
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			match <= 1'b0;
		end else begin
			match <= words.valid && near_full && (window_next == sync_header);
		end
	end

endmodule

/* word_counter.sv */
`timescale 1ns/1ps

module word_counter #(
	parameter int packet_words = 87
) (
	input  logic bclk,
	input  logic rst_n,
	input  logic start,
	input  logic step,
	output logic last
);

	localparam int cnt_w = $clog2(packet_words + 1);

	logic [cnt_w-1:0] left;

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			left <= '0;
		end else if (start) begin
			left <= cnt_w'(packet_words);
		end else if (step && left != '0) begin
			left <= left - 1'b1;
		end
	end

	assign last = left == cnt_w'(1); // One word still to go.

endmodule

/* capture_fsm.sv */
`timescale 1ns/1ps

module capture_fsm import i2s_rx_pkg::*; #(
	parameter int stream_id = 0
) (
	input  logic         bclk,
	input  logic         rst_n,
	i2s_word_if.consumer words,
	input  logic         match,
	output logic         start,
	output logic         step,
	input  logic         last,
	output fifo_entry_t  entry,
	output logic         wr_en
);

	cap_state_t state;

	// Match is ignored once a packet is underway.
	assign start = (state == cap_idle) && match;
	assign step  = (state == cap_payload) && words.valid;
	assign wr_en = step;

	always_comb begin
		entry         = '0;
		entry.id      = id_width'(stream_id);
		entry.channel = words.channel;
		entry.word    = words.word;
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			state <= cap_idle;
		end else begin
			case (state)
				cap_idle: begin
					if (match) begin
						state <= cap_payload;
					end
				end
				cap_payload: begin
					if (words.frame_err) begin
						state <= cap_idle; // Drop the rest of the packet.
					end else if (words.valid && last) begin
						state <= cap_idle;
					end
				end
				default: begin
					state <= cap_idle;
				end
			endcase
		end
	end

endmodule

/* packet_fifo.sv */
`timescale 1ns/1ps

module packet_fifo import i2s_rx_pkg::*; #(
	parameter int fifo_depth = 128
) (
	input  logic        bclk,
	input  logic        rst_n,
	input  fifo_entry_t entry,
	input  logic        wr_en,
	input  logic        rd_en,
	output fifo_entry_t rdata,
	output logic        r_ready,
	output logic        error_full,
	output logic        error_empty
);

	localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cw = $clog2(fifo_depth + 1);
	localparam logic [aw-1:0] last_addr = aw'(fifo_depth - 1);

	fifo_entry_t     mem [fifo_depth];
	logic [aw-1:0]   wr_ptr;
	logic [aw-1:0]   rd_ptr;
	logic [cw-1:0]   count;
	logic            full;
	logic            empty;
	logic            do_wr;
	logic            do_rd;

	assign full  = count == cw'(fifo_depth);
	assign empty = count == '0;
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign rdata   = mem[rd_ptr]; // Head shows without a pop.
	assign r_ready = !empty;

	always_ff @(posedge bclk) begin
		if (do_wr) begin
			mem[wr_ptr] <= entry;
		end
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			error_full  <= 1'b0;
			error_empty <= 1'b0;
		end else begin
			if (wr_en && full) begin
				error_full <= 1'b1; // Held until reset.
			end
			if (rd_en && empty) begin
				error_empty <= 1'b1;
			end
		end
	end

endmodule

/* i2s_packet_rx.sv */
`timescale 1ns/1ps

module i2s_packet_rx import i2s_rx_pkg::*; #(
	parameter int sample_width = 24,
	parameter int packet_words = 87,
	parameter int fifo_depth   = 128,
	parameter int stream_id    = 0
) (
	input  logic        bclk,
	input  logic        rst_n,
	input  logic        lrclk,
	input  logic        sdata,
	input  logic        r_enable,
	output logic [31:0] rdata,
	output logic        r_ready,
	output logic        error_full,
	output logic        error_empty
);

	i2s_word_if words ();

	logic        match;
	logic        start;
	logic        step;
	logic        last;
	logic        wr_en;
	fifo_entry_t entry;
	fifo_entry_t head;

	assign rdata = head;

	i2s_deserializer #(
		.sample_width(sample_width)
	) u_deser (
		.bclk(bclk),
		.rst_n(rst_n),
		.lrclk(lrclk),
		.sdata(sdata),
		.words(words.producer)
	);

	header_matcher u_match (
		.bclk(bclk),
		.rst_n(rst_n),
		.words(words.consumer),
		.match(match)
	);

	capture_fsm #(
		.stream_id(stream_id)
	) u_capture (
		.bclk(bclk),
		.rst_n(rst_n),
		.words(words.consumer),
		.match(match),
		.start(start),
		.step(step),
		.last(last),
		.entry(entry),
		.wr_en(wr_en)
	);

	word_counter #(
		.packet_words(packet_words)
	) u_count (
		.bclk(bclk),
		.rst_n(rst_n),
		.start(start),
		.step(step),
		.last(last)
	);

	packet_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.bclk(bclk),
		.rst_n(rst_n),
		.entry(entry),
		.wr_en(wr_en),
		.rd_en(r_enable),
		.rdata(head),
		.r_ready(r_ready),
		.error_full(error_full),
		.error_empty(error_empty)
	);

endmodule

/* tb_i2s_packet_rx.sv */
`timescale 1ns/1ps

module tb_i2s_packet_rx import i2s_rx_pkg::*; ();

	localparam int tb_packet_words = 8;
	localparam int tb_fifo_depth   = 16;
	localparam int tb_stream_id    = 5;
	localparam int slot_len        = 32;
	localparam int short_len       = 16;
	localparam int n_rows          = 8;
	localparam logic [15:0] hdr_words [5] = '{16'h0B77, 16'hA1DD, 16'h4240, 16'h2F84, 16'h2B03};

	typedef struct packed {
		int filler;      // Words before each header.
		int header;
		int corrupt;     // Header word to break, counted from 1.
		int short_at;    // Short slot added at this slot, counted from 1.
		int payload;
		int embed;       // Header copied into payload words 1 to 5.
		int packets;
		int read_mode;   // 0 none, 1 drain, 2 drain and pop once more.
		int exp_entries;
		int exp_full;
		int exp_empty;
	} row_t;

	logic        bclk;
	logic        rst_n;
	logic        lrclk;
	logic        sdata;
	logic        r_enable;
	logic [31:0] rdata;
	logic        r_ready;
	logic        error_full;
	logic        error_empty;

	row_t        rows [n_rows];
	string       test_name [n_rows];
	logic [23:0] samples [$];
	bit          shorts [$];
	fifo_entry_t exp_q [$];
	logic [31:0] lfsr;
	int          errors;
	int          test_errors;
	int          passed;
	int          cycles;
	int          limit;

	i2s_packet_rx #(
		.sample_width(24),
		.packet_words(tb_packet_words),
		.fifo_depth(tb_fifo_depth),
		.stream_id(tb_stream_id)
	) dut0 (
		.bclk(bclk),
		.rst_n(rst_n),
		.lrclk(lrclk),
		.sdata(sdata),
		.r_enable(r_enable),
		.rdata(rdata),
		.r_ready(r_ready),
		.error_full(error_full),
		.error_empty(error_empty)
	);

	initial begin
		bclk = 1'b0;
		forever #5 bclk = ~bclk;
	end

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge bclk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Checks failed");
		$finish;
	end

	// Galois LFSR, one step per bit taken.
	function automatic logic [31:0] next_bits(int n);
		logic [31:0] bits;
		logic        lsb;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			lsb  = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ 32'h8020_0003;
			end
			bits = {bits[30:0], lsb};
		end
		return bits;
	endfunction

	function automatic logic slot_level(int s);
		return ~s[0]; // Slot 0 is a right slot.
	endfunction

	task automatic push_sample(logic [15:0] w);
		logic [31:0] low;
		low = next_bits(8);
		samples.push_back({w, low[7:0]});
		shorts.push_back(1'b0);
	endtask

	task automatic build_stream(row_t r);
		logic [15:0] w;
		logic [31:0] bits;
		samples.delete();
		shorts.delete();
		for (int p = 0; p < r.packets; p++) begin
			for (int f = 0; f < r.filler; f++) begin
				bits = next_bits(16);
				push_sample(bits[15:0]);
			end
			for (int k = 0; k < 5 && r.header != 0; k++) begin
				w = (r.corrupt == k + 1) ? hdr_words[k] ^ 16'h0040 : hdr_words[k];
				push_sample(w);
			end
			for (int j = 0; j < r.payload; j++) begin
				if (r.embed != 0 && j >= 1 && j <= 5) begin
					w = hdr_words[j - 1];
				end else begin
					bits = next_bits(16);
					w = bits[15:0];
				end
				push_sample(w);
			end
		end
		if (r.short_at != 0) begin
			bits = next_bits(24);
			samples.insert(r.short_at - 1, bits[23:0]); // Extra slot, cut short.
			shorts.insert(r.short_at - 1, 1'b1);
		end
	endtask

	// Reference model of matcher, capture and FIFO depth, one step per slot.
	task automatic build_expected();
		logic [15:0] win [$];
		fifo_entry_t e;
		bit          capturing;
		bit          hit;
		int          left;
		exp_q.delete();
		capturing = 1'b0;
		left = 0;
		for (int s = 0; s < samples.size(); s++) begin
			if (shorts[s]) begin
				win.delete();
				capturing = 1'b0;
			end else begin
				if (capturing) begin
					e = '0;
					e.id = id_width'(tb_stream_id);
					e.channel = channel_t'(slot_level(s));
					e.word = samples[s][23:8];
					if (exp_q.size() < tb_fifo_depth) begin
						exp_q.push_back(e);
					end
					left--;
					capturing = left > 0;
				end
				win.push_back(samples[s][23:8]);
				if (win.size() > 5) begin
					void'(win.pop_front());
				end
				hit = win.size() == 5;
				for (int k = 0; k < win.size(); k++) begin
					if (win[k] != hdr_words[k]) begin
						hit = 1'b0;
					end
				end
				if (hit && !capturing) begin
					capturing = 1'b1;
					left = tb_packet_words;
				end
			end
		end
	endtask

	task automatic send_slot(logic [23:0] smp, logic level, bit short_slot);
		int len;
		len = short_slot ? short_len : slot_len;
		for (int i = 0; i < len; i++) begin
			@(negedge bclk);
			lrclk = level;
			sdata = (i >= 1 && i <= 24) ? smp[24 - i] : 1'b0; // One-bit delay.
		end
	endtask

	task automatic send_stream();
		for (int s = 0; s < samples.size(); s++) begin
			send_slot(samples[s], slot_level(s), shorts[s]);
		end
		@(negedge bclk);
		lrclk = slot_level(samples.size()); // Closing edge flushes the last word.
		sdata = 1'b0;
		repeat (6) @(negedge bclk);
	endtask

	task automatic apply_reset();
		@(negedge bclk);
		rst_n = 1'b0;
		lrclk = 1'b0;
		sdata = 1'b0;
		r_enable = 1'b0;
		repeat (10) @(negedge bclk);
		rst_n = 1'b1;
		repeat (2) @(negedge bclk);
	endtask

	task automatic check_entry(string name, fifo_entry_t exp, fifo_entry_t act);
		if (act !== exp) begin
			$display("mismatch %s: entry expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_flag(string name, string what, logic exp, logic act);
		if (act !== exp) begin
			$display("mismatch %s: %s expected %b actual %b", name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			$display("mismatch %s: entry count expected %0d actual %0d", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic drain_fifo(string name, int exp_entries, int read_mode);
		fifo_entry_t got;
		fifo_entry_t exp;
		int          popped;
		popped = 0;
		@(negedge bclk);
		while (r_ready && popped < tb_fifo_depth + 2) begin
			got = fifo_entry_t'(rdata);
			if (exp_q.size() > 0) begin
				exp = exp_q.pop_front();
				check_entry(name, exp, got);
			end
			popped++;
			r_enable = 1'b1;
			@(negedge bclk);
		end
		r_enable = 1'b0;
		check_count(name, exp_entries, popped);
		if (read_mode == 2) begin
			r_enable = 1'b1; // Pop on an empty FIFO.
			@(negedge bclk);
			r_enable = 1'b0;
			@(negedge bclk);
		end
	endtask

	task automatic run_test(int i);
		row_t r;
		r = rows[i];
		test_errors = 0;
		apply_reset();
		build_stream(r);
		build_expected();
		send_stream();
		check_flag(test_name[i], "error_full", r.exp_full != 0, error_full);
		if (r.read_mode == 0) begin
			check_flag(test_name[i], "r_ready", r.exp_entries != 0, r_ready);
		end else begin
			drain_fifo(test_name[i], r.exp_entries, r.read_mode);
		end
		check_flag(test_name[i], "error_empty", r.exp_empty != 0, error_empty);
		errors += test_errors;
		if (test_errors == 0) begin
			passed++;
			$display("%s: pass", test_name[i]);
		end else begin
			$display("%s: FAIL with %0d errors", test_name[i], test_errors);
		end
	endtask

	task automatic fill_table();
		// filler, header, corrupt, short_at, payload, embed, packets,
		// read_mode, exp_entries, exp_full, exp_empty
		test_name[0] = "clean_packet";
		rows[0] = '{4, 1, 0, 0, 8, 0, 1, 1, 8, 0, 0};
		test_name[1] = "bad_header_w0";
		rows[1] = '{4, 1, 1, 0, 8, 0, 1, 0, 0, 0, 0};
		test_name[2] = "bad_header_w2";
		rows[2] = '{4, 1, 3, 0, 8, 0, 1, 0, 0, 0, 0};
		test_name[3] = "bad_header_w4";
		rows[3] = '{4, 1, 5, 0, 8, 0, 1, 0, 0, 0, 0};
		test_name[4] = "short_in_header";
		rows[4] = '{3, 1, 0, 7, 8, 0, 1, 1, 0, 0, 0};
		test_name[5] = "short_in_payload";
		rows[5] = '{3, 1, 0, 13, 8, 0, 1, 1, 4, 0, 0};
		test_name[6] = "header_in_payload";
		rows[6] = '{2, 1, 0, 0, 8, 1, 2, 1, 16, 0, 0};
		test_name[7] = "overflow_underflow";
		rows[7] = '{2, 1, 0, 0, 8, 0, 3, 2, 16, 1, 1};
	endtask

	function automatic int slot_budget();
		int total;
		total = 0;
		for (int i = 0; i < n_rows; i++) begin
			total += rows[i].packets * (rows[i].filler + 5 * rows[i].header + rows[i].payload);
			total += 1 + (rows[i].short_at != 0); // Closing edge and any short slot.
		end
		return total * slot_len * 12 / 10; // 20% margin.
	endfunction

	initial begin
		rst_n = 1'b0;
		lrclk = 1'b0;
		sdata = 1'b0;
		r_enable = 1'b0;
		lfsr = 32'h58fd_88fb;
		errors = 0;
		passed = 0;
		fill_table();
		limit = slot_budget();
		for (int i = 0; i < n_rows; i++) begin
			run_test(i);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", n_rows, passed,
			n_rows - passed, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* sim.f */
i2s_rx_pkg.sv
i2s_word_if.sv
i2s_deserializer.sv
header_matcher.sv
word_counter.sv
capture_fsm.sv
packet_fifo.sv
i2s_packet_rx.sv
tb_i2s_packet_rx.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0 --timescale 1ns/1ps
TOP       = tb_i2s_packet_rx
FILELIST  = sim.f
PASS_MSG  = All checks passed

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf obj_dir
